// File: Bender.yml
package:
  name: uart_periph

sources:
  - include_dirs:
      - common
    files:
      - common/uart_bus_pkg.sv
      - common/uart_line_pkg.sv
      - uart/uart_transmitter.sv
      - uart/uart_receiver.sv
      - source/uart_regs.sv
      - source/uart_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/uart_sva.sv
      - tests/uart_checker.sv
      - tests/tb_uart.sv

// File: common/uart_bus_pkg.sv
// host side types only and every register is one 32 bit word
`default_nettype none

`include "uart_cfg.svh"

package uart_bus_pkg;

    typedef struct packed {
        logic [13:0] rsvd;
        logic        rec_en;        // receiver enable
        logic        tr_en;         // transmitter enable
        logic [15:0] comp;          // bit time is comp+1 clocks
    } ctrl_view_t;

    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  data;          // tx or rx byte
    } data_view_t;

    // same 32 bits, decoded by address
    typedef union packed {
        ctrl_view_t ctrl_view;
        data_view_t data_view;
    } reg_word_u;

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`UART_ADDR_W-1:0] addr;
        reg_word_u               wdata;
    } bus_req_t;

    typedef struct packed {
        logic        rvalid;        // one cycle after a read request
        logic [31:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: common/uart_cfg.svh
// sizes are fixed at elaboration and the address macros assume UART_ADDR_W is 2
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

`define UART_TX_DEPTH       4       // tx queue entries, also host credits after reset
`define UART_ADDR_W         2       // host bus address width

`define UART_ADDR_CTRL      2'd0    // tr_en, rec_en, comp
`define UART_ADDR_TXDATA    2'd1    // push one byte, spends a credit
`define UART_ADDR_RXDATA    2'd2    // read clears rx_full
`define UART_ADDR_STATUS    2'd3    // rx_full, overrun, tx_busy, queue level

`endif

// File: common/uart_line_pkg.sv
// internal UART block types and the data fields always carry a whole 8 bit byte
`default_nettype none

package uart_line_pkg;

    // queue head offered to the transmitter
    typedef struct packed {
        logic       req;            // level, held until the byte is latched
        logic [7:0] data;
    } tx_req_t;

    // one cycle strobe per good frame
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

endpackage

`default_nettype wire

// File: project.f
+incdir+common
common/uart_bus_pkg.sv
common/uart_line_pkg.sv
uart/uart_transmitter.sv
uart/uart_receiver.sv
source/uart_regs.sv
source/uart_top.sv
tests/uart_sva.sv
tests/uart_checker.sv
tests/tb_uart.sv

// File: source/uart_regs.sv
// TXDATA writes while the queue is full are dropped and on overrun the older byte is kept
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_regs
    import uart_bus_pkg::*;
    import uart_line_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  bus_req_t    bus_req,
    input  logic        req_ack,    // transmitter finished the head byte
    input  rx_byte_t    rx_byte,
    output bus_rsp_t    bus_rsp,
    output logic        tx_credit,  // one pulse per byte sent
    output tx_req_t     tx_req,
    output logic        tr_en,
    output logic        rec_en,
    output logic [15:0] comp
);

    localparam int DEPTH = `UART_TX_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       q_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             q_empty;
    logic             q_full;
    logic             push;
    logic             pop;
    logic             in_flight;    // head byte latched by the transmitter
    logic             ctrl_wr;
    logic             rx_rd;
    logic             rx_store;
    logic             rx_full;
    logic             overrun;
    logic [7:0]       rx_data;
    logic             rvalid_q;
    logic [31:0]      rdata_q;
    reg_word_u        rd_word;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign ctrl_wr  = bus_req.valid && bus_req.write && bus_req.addr == `UART_ADDR_CTRL;
    assign push     = bus_req.valid && bus_req.write && bus_req.addr == `UART_ADDR_TXDATA
                      && !q_full;
    assign rx_rd    = bus_req.valid && !bus_req.write && bus_req.addr == `UART_ADDR_RXDATA;
    assign q_empty  = q_count == '0;
    assign q_full   = q_count == CNT_W'(DEPTH);
    assign pop      = req_ack && !q_empty;
    assign rx_store = rx_byte.valid && (!rx_full || rx_rd);

    assign tx_credit = pop;         // same cycle as the pop
    assign tx_req    = '{req: !q_empty && !in_flight, data: q_mem[rd_ptr]};

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            in_flight <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop)
                q_count <= q_count + 1'b1;
            else if (pop && !push)
                q_count <= q_count - 1'b1;
            if (!tr_en || pop)
                in_flight <= 1'b0;      // abort leaves the byte queued
            else if (tx_req.req)
                in_flight <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            q_mem[wr_ptr] <= bus_req.wdata.data_view.data;
        if (rx_store)
            rx_data <= rx_byte.data;
        if (bus_req.valid && !bus_req.write)
            rdata_q <= rd_word;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            tr_en    <= 1'b0;
            rec_en   <= 1'b0;
            comp     <= '0;
            rx_full  <= 1'b0;
            overrun  <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            rvalid_q <= bus_req.valid && !bus_req.write;
            if (ctrl_wr)
            begin
                tr_en   <= bus_req.wdata.ctrl_view.tr_en;
                rec_en  <= bus_req.wdata.ctrl_view.rec_en;
                comp    <= bus_req.wdata.ctrl_view.comp;
                overrun <= 1'b0;
            end
            if (rx_byte.valid && rx_full && !rx_rd)
                overrun <= 1'b1;        // sticky
            if (rx_rd)
                rx_full <= 1'b0;
            if (rx_store)
                rx_full <= 1'b1;
        end
    end

    // status layout is rx_full, overrun, tx_busy, then queue level from bit 8
    always_comb
    begin
        rd_word = '0;
        case (bus_req.addr)
            `UART_ADDR_CTRL:
            begin
                rd_word.ctrl_view.tr_en  = tr_en;
                rd_word.ctrl_view.rec_en = rec_en;
                rd_word.ctrl_view.comp   = comp;
            end
            `UART_ADDR_RXDATA:
                rd_word.data_view.data = rx_data;
            `UART_ADDR_STATUS:
            begin
                rd_word[0]         = rx_full;
                rd_word[1]         = overrun;
                rd_word[2]         = in_flight;
                rd_word[8 +: CNT_W] = q_count;
            end
            default:
                rd_word = '0;
        endcase
    end

    assign bus_rsp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: source/uart_top.sv
// host must follow the tx_credit flow control and the line idles until CTRL enables it
`timescale 1ns/1ps
`default_nettype none

module uart_top
    import uart_bus_pkg::*;
    import uart_line_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  bus_req_t bus_req,       // from the host
    output bus_rsp_t bus_rsp,
    output logic     tx_credit,     // returns one host credit
    output logic     uart_tx,
    input  logic     uart_rx
);

    tx_req_t     tx_req;
    rx_byte_t    rx_byte;
    logic        req_ack;
    logic        tr_en;
    logic        rec_en;
    logic [15:0] comp;

    uart_regs u_regs (
        .clk       (clk),
        .resetn    (resetn),
        .bus_req   (bus_req),
        .req_ack   (req_ack),
        .rx_byte   (rx_byte),
        .bus_rsp   (bus_rsp),
        .tx_credit (tx_credit),
        .tx_req    (tx_req),
        .tr_en     (tr_en),
        .rec_en    (rec_en),
        .comp      (comp)
    );

    uart_transmitter u_tx (
        .clk     (clk),
        .resetn  (resetn),
        .tr_en   (tr_en),
        .comp    (comp),
        .tx_req  (tx_req),
        .req_ack (req_ack),
        .uart_tx (uart_tx)
    );

    uart_receiver u_rx (
        .clk     (clk),
        .resetn  (resetn),
        .rec_en  (rec_en),
        .comp    (comp),
        .uart_rx (uart_rx),
        .rx_byte (rx_byte)
    );

endmodule

`default_nettype wire

// File: tests/tb_uart.sv
// one clock domain, loopback on uart_tx, comp is random per run and fixed once set
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module tb_uart
    import uart_bus_pkg::*;
;
    logic     clk;
    logic     resetn;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     tx_credit;
    logic     uart_tx;
    logic     uart_rx;
    logic     loop_en;              // low for the disabled transmitter test
    int       phase;
    int       credits;              // host side credit count
    int       comp;

    assign uart_rx = loop_en ? uart_tx : 1'b1;

    uart_top u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .tx_credit (tx_credit),
        .uart_tx   (uart_tx),
        .uart_rx   (uart_rx)
    );

    uart_checker u_chk (
        .clk       (clk),
        .resetn    (resetn),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .tx_credit (tx_credit),
        .uart_tx   (uart_tx),
        .loop_en   (loop_en),
        .phase     (phase)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        if (resetn && tx_credit)
            credits = credits + 1;  // credit comes back
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic bus_access(input logic wr, input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        bus_req.valid = 1'b1;
        bus_req.write = wr;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        @(posedge clk);
        #2;
        bus_req = '0;
    endtask

    task automatic write_ctrl(input logic rx_on, input logic tx_on);
        bus_access(1'b1, `UART_ADDR_CTRL, {14'd0, rx_on, tx_on, comp[15:0]});
    endtask

    task automatic send_byte(input logic [7:0] b);
        int t;
        for (t = 0; t < 200000 && credits == 0; t++)
            @(posedge clk);
        if (credits == 0)
            stop_on_timeout("a transmit credit");
        credits = credits - 1;
        bus_access(1'b1, `UART_ADDR_TXDATA, {24'd0, b});
    endtask

    task automatic wait_idle();
        int t;
        for (t = 0; t < 60 * (comp + 1) * `UART_TX_DEPTH && credits != `UART_TX_DEPTH; t++)
            @(posedge clk);
        if (credits != `UART_TX_DEPTH)
            stop_on_timeout("all credits to return");
        repeat (comp + 12) @(posedge clk);     // receiver finishes after the stop bit
    endtask

    initial
    begin
        int i;
        clk     = 1'b0;
        resetn  = 1'b0;
        bus_req = '0;
        loop_en = 1'b1;
        phase   = 1;
        credits = `UART_TX_DEPTH;
        void'($urandom(32'h9401_300c));
        comp    = 3 + ($urandom % 18);
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b1;
        // single bytes through loopback, read back each one
        phase = 2;
        write_ctrl(1'b1, 1'b1);
        for (i = 0; i < 6; i++)
        begin
            send_byte($urandom);
            wait_idle();
            bus_access(1'b0, `UART_ADDR_STATUS, '0);
            bus_access(1'b0, `UART_ADDR_RXDATA, '0);
            bus_access(1'b0, `UART_ADDR_STATUS, '0);
        end
        // burst at full credit rate, receiver off
        phase = 1;
        write_ctrl(1'b0, 1'b1);
        for (i = 0; i < 10; i++)
            send_byte($urandom);
        wait_idle();
        phase = 3;
        u_chk.check_credits();
        // overrun
        phase = 4;
        write_ctrl(1'b1, 1'b1);
        send_byte($urandom);
        send_byte($urandom);
        wait_idle();
        bus_access(1'b0, `UART_ADDR_STATUS, '0);
        bus_access(1'b0, `UART_ADDR_RXDATA, '0);
        write_ctrl(1'b1, 1'b1);
        bus_access(1'b0, `UART_ADDR_STATUS, '0);
        // transmitter disabled
        phase   = 5;
        loop_en = 1'b0;
        write_ctrl(1'b0, 1'b0);
        for (i = 0; i < 3; i++)
            send_byte($urandom);
        repeat (12 * (comp + 1)) @(posedge clk);
        $display("Errors: %0d value, %0d other, %0d assertion, %0d frames checked",
                 u_chk.value_errors, u_chk.other_errors, u_dut.u_sva.assert_fails,
                 u_chk.frames);
        if (u_chk.value_errors + u_chk.other_errors + u_dut.u_sva.assert_fails == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/uart_checker.sv
// models one host, checks every clock of each uart_tx frame and assumes reads happen away from frame ends
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_checker
    import uart_bus_pkg::*;
(
    input wire logic     clk,
    input wire logic     resetn,
    input wire bus_req_t bus_req,
    input wire bus_rsp_t bus_rsp,
    input wire logic     tx_credit,
    input wire logic     uart_tx,
    input wire logic     loop_en,
    input var  int       phase
);
    int         value_errors = 0;
    int         other_errors = 0;
    int         frames = 0;
    int         pulses = 0;
    int         credits = `UART_TX_DEPTH;
    int         level = 0;          // model queue occupancy
    logic       tr_en_m = 0;
    logic       rec_en_m = 0;
    logic [15:0] comp_m = 0;
    logic       full_m = 0;
    logic       ovr_m = 0;
    logic [7:0] rx_m = 0;
    logic [7:0] exp_q[$];
    logic       pend = 0;
    logic [31:0] exp_rd;
    logic [31:0] rd_mask;

    function automatic string test_name(input int p);
        case (p)
            1: return "tx_frame";
            2: return "loopback_read";
            3: return "credit_count";
            4: return "overrun";
            default: return "tx_disabled";
        endcase
    endfunction

    task automatic value_check(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("Error: %s expected %h actual %h", test_name(phase), exp, act);
            value_errors++;
        end
    endtask

    task automatic check_credits();
        value_check(0, exp_q.size());   // every written byte went out
        value_check(frames, pulses);
    endtask

    // bus side model
    always @(posedge clk)
    begin
        if (resetn)
        begin
            if (pend)
                value_check(exp_rd, bus_rsp.rdata & rd_mask);
            else if (bus_rsp.rvalid)
            begin
                $display("Read data came back with no read pending");
                other_errors++;
            end
            pend = bus_req.valid && !bus_req.write;
            rd_mask = 32'hffff_ffff;
            case (bus_req.addr)
                `UART_ADDR_CTRL:   exp_rd = {14'd0, rec_en_m, tr_en_m, comp_m};
                `UART_ADDR_RXDATA: exp_rd = {24'd0, rx_m};
                default:
                begin
                    exp_rd  = {21'd0, 3'(level), 6'd0, ovr_m, full_m};
                    rd_mask = 32'h0000_0703;    // busy bit not modelled
                end
            endcase
            if (pend && bus_req.addr == `UART_ADDR_RXDATA)
                full_m = 1'b0;
            if (bus_req.valid && bus_req.write && bus_req.addr == `UART_ADDR_CTRL)
            begin
                tr_en_m  = bus_req.wdata.ctrl_view.tr_en;
                rec_en_m = bus_req.wdata.ctrl_view.rec_en;
                comp_m   = bus_req.wdata.ctrl_view.comp;
                ovr_m    = 1'b0;
            end
            if (bus_req.valid && bus_req.write && bus_req.addr == `UART_ADDR_TXDATA)
            begin
                if (credits == 0)
                begin
                    $display("Host wrote TX data with no credit left");
                    other_errors++;
                end
                credits--;
                exp_q.push_back(bus_req.wdata.data_view.data);
                level++;
            end
            if (tx_credit)
            begin
                credits++;
                pulses++;
                level--;
            end
        end
    end

    // serial decoder, each clock must match the first clock of its bit
    initial
    begin
        logic       prev;
        logic       lvl;
        logic [7:0] b;
        int         bl;
        int         i;
        prev = 1'b1;
        forever
        begin
            @(posedge clk);
            if (resetn && prev && !uart_tx)
            begin
                if (!tr_en_m)
                begin
                    $display("A frame started while the transmitter was disabled");
                    other_errors++;
                end
                bl  = comp_m + 1;
                lvl = 1'b0;
                for (i = 0; i < 10 * bl; i++)
                begin
                    if (i > 0)
                        @(posedge clk);
                    if (i % bl == 0)
                        lvl = uart_tx;          // first clock of a bit
                    else if (uart_tx !== lvl)
                    begin
                        $display("Bit %0d of a frame did not last comp+1 clocks", i / bl);
                        other_errors++;
                        lvl = uart_tx;
                    end
                    if (i / bl >= 1 && i / bl <= 8)
                        b[i / bl - 1] = uart_tx;    // LSB first
                end
                value_check(1, lvl);            // stop bit
                if (exp_q.size() == 0)
                begin
                    $display("A frame appeared with no byte written");
                    other_errors++;
                end
                else
                    value_check(exp_q.pop_front(), b);
                frames++;
                if (loop_en && rec_en_m)
                begin
                    if (full_m)
                        ovr_m = 1'b1;
                    else
                    begin
                        rx_m   = b;
                        full_m = 1'b1;
                    end
                end
            end
            prev = uart_tx;
        end
    end

endmodule

`default_nettype wire

// File: tests/uart_sva.sv
// bound into every uart_top instance and reaches u_regs.q_count by hierarchy
`timescale 1ns/1ps
`default_nettype none

module uart_sva
    import uart_bus_pkg::*;
(
    input wire logic     clk,
    input wire logic     resetn,
    input wire bus_req_t bus_req,
    input wire bus_rsp_t bus_rsp,
    input wire logic     tx_credit,
    input wire logic     uart_tx,
    input wire logic     tr_en,
    input wire logic     req_ack,
    input wire logic [2:0] q_count
);
    logic rd_req;
    int   assert_fails = 0;         // failed assertion count

    assign rd_req = bus_req.valid && !bus_req.write;

    line_idle_when_off: assert property (@(posedge clk) disable iff (!resetn)
        !tr_en |=> uart_tx)
    else
    begin
        $error("uart_tx low while the transmitter is disabled");
        assert_fails++;
    end

    rvalid_after_read: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |=> bus_rsp.rvalid)
    else
    begin
        $error("no rvalid one cycle after a read");
        assert_fails++;
    end

    rvalid_only_after_read: assert property (@(posedge clk) disable iff (!resetn)
        bus_rsp.rvalid |-> $past(rd_req))
    else
    begin
        $error("rvalid without a read in the cycle before");
        assert_fails++;
    end

    // a finished byte must come from a queued entry and hand back its credit
    credit_needs_queue: assert property (@(posedge clk) disable iff (!resetn)
        req_ack |-> tx_credit && q_count != 3'd0)
    else
    begin
        $error("transmitter finished a byte with an empty queue or no credit");
        assert_fails++;
    end

endmodule

bind uart_top uart_sva u_sva (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .tx_credit (tx_credit),
    .uart_tx   (uart_tx),
    .tr_en     (tr_en),
    .req_ack   (req_ack),
    .q_count   (u_regs.q_count)
);

`default_nettype wire

// File: uart/uart_receiver.sv
// 8N1 only and a frame with a low stop bit is dropped without any report
`timescale 1ns/1ps
`default_nettype none

module uart_receiver
    import uart_line_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        rec_en,     // low holds the FSM in idle
    input  logic [15:0] comp,       // baud compare
    input  logic        uart_rx,    // asynchronous serial line
    output rx_byte_t    rx_byte     // valid in the middle of the stop bit
);

    typedef enum logic [1:0] {
        IDLE_S,
        START_S,
        DATA_S,
        STOP_S
    } rx_state_e;

    rx_state_e   state;
    logic [1:0]  sync_q;            // two-flop synchroniser
    logic        rx_s;
    logic        rx_prev;           // for falling edge detect
    logic [15:0] baud_cnt;
    logic [16:0] bit_len;
    logic [15:0] half_bit;
    logic        bit_end;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift_q;
    logic        valid_q;

    assign rx_s     = sync_q[1];
    assign bit_len  = {1'b0, comp} + 17'd1;
    assign half_bit = bit_len[16:1];
    assign bit_end  = baud_cnt >= comp;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            sync_q  <= {sync_q[0], uart_rx};
            rx_prev <= rx_s;
        end
    end

    // the two sync stages make up for detecting the edge late
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= IDLE_S;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end
        else if (!rec_en)
        begin
            state    <= IDLE_S;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            case (state)
                IDLE_S:
                begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (rx_prev && !rx_s)
                        state <= START_S;
                end
                START_S:
                begin
                    baud_cnt <= baud_cnt + 16'd1;
                    if (baud_cnt >= half_bit)
                    begin
                        baud_cnt <= '0;
                        state    <= rx_s ? IDLE_S : DATA_S;    // glitch goes back
                    end
                end
                DATA_S:
                begin
                    baud_cnt <= baud_cnt + 16'd1;
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= STOP_S;
                    end
                end
                STOP_S:
                begin
                    baud_cnt <= baud_cnt + 16'd1;
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        valid_q  <= rx_s;       // good stop bit only
                        state    <= IDLE_S;
                    end
                end
                default:
                    state <= IDLE_S;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == DATA_S && bit_end)
            shift_q <= {rx_s, shift_q[7:1]};    // LSB arrives first
    end

    assign rx_byte = '{valid: valid_q, data: shift_q};

endmodule

`default_nettype wire

// File: uart/uart_transmitter.sv
// 8N1 only and comp is read live so change it only while idle, dropping tr_en loses the frame
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter
    import uart_line_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        tr_en,      // low forces idle and a high line
    input  logic [15:0] comp,       // baud compare
    input  tx_req_t     tx_req,     // byte from the queue
    output logic        req_ack,    // one cycle, end of stop bit
    output logic        uart_tx     // serial line, idles high
);

    typedef enum logic [2:0] {
        IDLE_S,
        START_S,
        DATA_S,
        STOP_S,
        WAIT_S
    } tx_state_e;

    tx_state_e   state;
    logic [15:0] baud_cnt;          // clocks within the current bit
    logic [2:0]  bit_cnt;           // data bit index, LSB first
    logic [7:0]  data_q;            // byte on the line
    logic        bit_end;

    assign bit_end = baud_cnt >= comp;

    // uart_tx is registered, so the line trails the state by one clock
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= IDLE_S;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            req_ack  <= 1'b0;
            uart_tx  <= 1'b1;
        end
        else if (!tr_en)
        begin
            state    <= IDLE_S;     // abort
            baud_cnt <= '0;
            bit_cnt  <= '0;
            req_ack  <= 1'b0;
            uart_tx  <= 1'b1;
        end
        else
        begin
            req_ack <= 1'b0;
            case (state)
                IDLE_S:
                begin
                    uart_tx  <= 1'b1;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (tx_req.req)
                        state <= START_S;
                end
                START_S:
                begin
                    uart_tx  <= 1'b0;
                    baud_cnt <= baud_cnt + 16'd1;
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        state    <= DATA_S;
                    end
                end
                DATA_S:
                begin
                    uart_tx  <= data_q[bit_cnt];
                    baud_cnt <= baud_cnt + 16'd1;
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;     // wraps to 0 after bit 7
                        if (bit_cnt == 3'd7)
                            state <= STOP_S;
                    end
                end
                STOP_S:
                begin
                    uart_tx  <= 1'b1;
                    baud_cnt <= baud_cnt + 16'd1;
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        req_ack  <= 1'b1;
                        state    <= WAIT_S;
                    end
                end
                WAIT_S:
                    state <= IDLE_S;    // req_ack visible here, queue pops
                default:
                    state <= IDLE_S;
            endcase
        end
    end

    // byte is captured as the FSM leaves idle
    always_ff @(posedge clk)
    begin
        if (state == IDLE_S && tx_req.req)
            data_q <= tx_req.data;
    end

endmodule

`default_nettype wire
